/* src/fetchPkg.sv */
// fetch stage shared definitions
package fetchPkg;

   // datapath widths
   localparam int unsigned addrWidth   = 16;
   localparam int unsigned instrWidth  = 16;
   localparam int unsigned regIdxWidth = 3;

   // instruction memory geometry, one word per 2-byte slot
   localparam int unsigned memDepth     = 256;
   localparam int unsigned memAddrWidth = $clog2(memDepth);

   // byte step between sequential instructions
   localparam int unsigned pcStep = 2;

   // bubble inserted while fetch is stalled
   localparam logic [instrWidth-1:0] nopInstr = 16'h0800;

   // major opcode, bits 15:11 of an instruction
   typedef enum logic [4:0] {
      HALT = 5'b00000,
      NOP  = 5'b00001,
      ADDI = 5'b01000,
      SUBI = 5'b01001,
      ST   = 5'b10000,
      LD   = 5'b10001,
      BEQZ = 5'b01100,
      BNEZ = 5'b01101,
      J    = 5'b00100,
      JR   = 5'b00101,
      JAL  = 5'b00110,
      ADD  = 5'b11011,
      LBI  = 5'b11000
   } opcodeT;

   // register file write of one later stage
   typedef struct packed {
      logic                   en;
      logic [regIdxWidth-1:0] idx;
   } regWriteT;

   // what a later stage (D, X, M or W) tells fetch
   typedef struct packed {
      regWriteT regWrite;
      logic     branch;
   } stageInfoT;

   // preload port of the instruction memory
   typedef struct packed {
      logic                    en;
      logic [memAddrWidth-1:0] addr;
      logic [instrWidth-1:0]   data;
   } memLoadT;

endpackage

/* src/pcUnit.sv */
// program counter and increment
`timescale 1ns/100ps

module pcUnit (
   input  logic                          clk,
   input  logic                          rstN,
   input  logic [fetchPkg::addrWidth-1:0] newPC,
   input  logic                          redirect,
   input  logic                          hold,
   input  logic                          createDump,
   output logic [fetchPkg::addrWidth-1:0] pc,
   output logic [fetchPkg::addrWidth-1:0] incPC,
   output logic                          err
);

   import fetchPkg::*;

   // one extra bit to catch the carry out of the increment
   logic [addrWidth:0]   incSum;
   logic [addrWidth-1:0] pcNext;
   logic                 pcLoad;

   assign incSum = {1'b0, pc} + (addrWidth+1)'(pcStep);
   assign incPC  = incSum[addrWidth-1:0];

   // wrapping past the top of the address space is an error
   assign err = incSum[addrWidth];

   // a resolved branch in memory wins over the sequential path
   assign pcNext = redirect ? newPC : incPC;

   // dump freezes everything
   // a hazard hold is overridden by the redirect, which flushes the stalled instruction
   assign pcLoad = ~createDump & ~(hold & ~redirect);

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         pc <= '0;
      end else if (pcLoad) begin
         pc <= pcNext;
      end
   end

endmodule

/* src/instrMem.sv */
// instruction memory
`timescale 1ns/100ps

module instrMem (
   input  logic                           clk,
   input  logic [fetchPkg::addrWidth-1:0]  pc,
   input  fetchPkg::memLoadT              memLoad,
   output logic [fetchPkg::instrWidth-1:0] rawInstr
);

   import fetchPkg::*;

   logic [instrWidth-1:0]   mem [memDepth];
   logic [memAddrWidth-1:0] wordAddr;

   // byte address to word index, bit 0 is always zero for aligned fetch
   assign wordAddr = pc[memAddrWidth:1];

   // asynchronous read, a same-cycle load is not yet visible
   assign rawInstr = mem[wordAddr];

   // preload before the program runs
   always_ff @(posedge clk) begin
      if (memLoad.en) begin
         mem[memLoad.addr] <= memLoad.data;
      end
   end

endmodule

/* src/hazardCtrl.sv */
// fetch hazard detection and bubble insertion
`timescale 1ns/100ps

module hazardCtrl (
   input  logic [fetchPkg::instrWidth-1:0] rawInstr,
   input  fetchPkg::stageInfoT            stageD,
   input  fetchPkg::stageInfoT            stageX,
   input  fetchPkg::stageInfoT            stageM,
   input  fetchPkg::stageInfoT            stageW,
   output logic [fetchPkg::instrWidth-1:0] instruction,
   output logic                           hold,
   output logic                           branchInstF
);

   import fetchPkg::*;

   opcodeT                 opcode;
   logic [regIdxWidth-1:0] rs;
   logic [regIdxWidth-1:0] rt;
   logic                   readsRs;
   logic                   readsRt;
   logic                   isBranch;
   logic                   dataHazard;
   logic                   ctrlHazard;

   // true when a pending write lands on a register this instruction reads
   function automatic logic writesSource(
      input regWriteT               w,
      input logic [regIdxWidth-1:0] srcA,
      input logic                   useA,
      input logic [regIdxWidth-1:0] srcB,
      input logic                   useB
   );
      logic hitA;
      logic hitB;
      hitA = useA && (w.idx == srcA);
      hitB = useB && (w.idx == srcB);
      return w.en && (hitA || hitB);
   endfunction

   assign opcode = opcodeT'(rawInstr[15:11]);
   assign rs     = rawInstr[10:8];
   assign rt     = rawInstr[7:5];

   // source operand usage per opcode
   always_comb begin
      readsRs  = 1'b0;
      readsRt  = 1'b0;
      isBranch = 1'b0;
      case (opcode)
         ADDI, SUBI, LD: begin
            readsRs = 1'b1;
         end
         BEQZ, BNEZ, JR: begin
            readsRs  = 1'b1;
            isBranch = 1'b1;
         end
         ST, ADD: begin
            readsRs = 1'b1;
            readsRt = 1'b1;
         end
         J, JAL: begin
            isBranch = 1'b1;
         end
         // HALT, NOP, LBI and unknown encodings read nothing
         default: begin
            readsRs  = 1'b0;
            readsRt  = 1'b0;
            isBranch = 1'b0;
         end
      endcase
   end

   // no forwarding in this design, so every in-flight writer counts
   assign dataHazard = writesSource(stageD.regWrite, rs, readsRs, rt, readsRt)
                     | writesSource(stageX.regWrite, rs, readsRs, rt, readsRt)
                     | writesSource(stageM.regWrite, rs, readsRs, rt, readsRt)
                     | writesSource(stageW.regWrite, rs, readsRs, rt, readsRt);

   // branches resolve in memory, writeback is already past the redirect
   assign ctrlHazard = stageD.branch | stageX.branch | stageM.branch;

   assign hold        = dataHazard | ctrlHazard;
   assign instruction = hold ? nopInstr : rawInstr;
   assign branchInstF = isBranch & ~hold;

endmodule

/* src/fetch.sv */
// instruction fetch stage
`timescale 1ns/100ps

module fetch (
   input  logic                           clk,
   input  logic                           rstN,
   input  logic [fetchPkg::addrWidth-1:0]  newPC,
   input  logic                           createDump,
   input  fetchPkg::stageInfoT            stageD,
   input  fetchPkg::stageInfoT            stageX,
   input  fetchPkg::stageInfoT            stageM,
   input  fetchPkg::stageInfoT            stageW,
   input  fetchPkg::memLoadT              memLoad,
   output logic [fetchPkg::instrWidth-1:0] instruction,
   output logic [fetchPkg::addrWidth-1:0]  incPC,
   output logic                           branchInstF,
   output logic                           err
);

   import fetchPkg::*;

   logic [addrWidth-1:0]  pc;
   logic [instrWidth-1:0] rawInstr;
   logic                  hold;

   pcUnit uPcUnit (
      .clk        (clk),
      .rstN       (rstN),
      .newPC      (newPC),
      .redirect   (stageM.branch),
      .hold       (hold),
      .createDump (createDump),
      .pc         (pc),
      .incPC      (incPC),
      .err        (err)
   );

   instrMem uInstrMem (
      .clk      (clk),
      .pc       (pc),
      .memLoad  (memLoad),
      .rawInstr (rawInstr)
   );

   hazardCtrl uHazardCtrl (
      .rawInstr    (rawInstr),
      .stageD      (stageD),
      .stageX      (stageX),
      .stageM      (stageM),
      .stageW      (stageW),
      .instruction (instruction),
      .hold        (hold),
      .branchInstF (branchInstF)
   );

endmodule

/* bench/fetch_properties.sv */
// fetch stage assertions
`timescale 1ns/100ps

module fetchProperties (
   input  logic                           clk,
   input  logic                           rstN,
   input  logic [fetchPkg::addrWidth-1:0]  newPC,
   input  logic                           createDump,
   input  fetchPkg::stageInfoT            stageD,
   input  fetchPkg::stageInfoT            stageX,
   input  fetchPkg::stageInfoT            stageM,
   input  fetchPkg::stageInfoT            stageW,
   input  fetchPkg::memLoadT              memLoad,
   input  logic [fetchPkg::instrWidth-1:0] instruction,
   input  logic [fetchPkg::addrWidth-1:0]  incPC,
   input  logic                           branchInstF,
   input  logic                           err
);

   import fetchPkg::*;

   int unsigned           failCount = 0;
   logic [instrWidth-1:0] shadowMem [memDepth];
   logic [addrWidth-1:0]  modelPc;
   logic [addrWidth:0]    modelSum;
   logic [instrWidth-1:0] fetched;
   logic [1:0]            srcUse;
   logic                  dataHaz;
   logic                  ctrlHaz;
   logic                  expHold;
   logic                  expBranch;
   logic [addrWidth-1:0]  prevIncPC;
   logic [addrWidth-1:0]  prevNewPC;

   // bit 1 marks a read of rs, bit 0 a read of rt
   function automatic logic [1:0] sourceUse(input logic [4:0] op);
      case (op)
         ADDI, SUBI, LD, BEQZ, BNEZ, JR: return 2'b10;
         ST, ADD: return 2'b11;
         default: return 2'b00;
      endcase
   endfunction

   function automatic logic isBranchOp(input logic [4:0] op);
      case (op)
         BEQZ, BNEZ, J, JR, JAL: return 1'b1;
         default: return 1'b0;
      endcase
   endfunction

   function automatic logic stageHits(
      input stageInfoT             s,
      input logic [instrWidth-1:0] w,
      input logic [1:0]            uses
   );
      logic rsHit;
      logic rtHit;
      rsHit = uses[1] && (s.regWrite.idx == w[10:8]);
      rtHit = uses[0] && (s.regWrite.idx == w[7:5]);
      return s.regWrite.en && (rsHit || rtHit);
   endfunction

   // copy of the program as it goes through the load port
   always_ff @(posedge clk) begin
      if (memLoad.en) begin
         shadowMem[memLoad.addr] <= memLoad.data;
      end
   end

   assign fetched   = shadowMem[modelPc[memAddrWidth:1]];
   assign srcUse    = sourceUse(fetched[15:11]);
   assign dataHaz   = stageHits(stageD, fetched, srcUse) | stageHits(stageX, fetched, srcUse)
                    | stageHits(stageM, fetched, srcUse) | stageHits(stageW, fetched, srcUse);
   assign ctrlHaz   = stageD.branch | stageX.branch | stageM.branch;
   assign expHold   = dataHaz | ctrlHaz;
   assign expBranch = isBranchOp(fetched[15:11]) & ~expHold;
   assign modelSum  = {1'b0, modelPc} + (addrWidth+1)'(pcStep);

   // reference PC, a redirect beats a hazard hold but not a dump
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         modelPc <= '0;
      end else if (!createDump && (!expHold || stageM.branch)) begin
         modelPc <= stageM.branch ? newPC : modelSum[addrWidth-1:0];
      end
   end

   always_ff @(posedge clk) begin
      prevIncPC <= incPC;
      prevNewPC <= newPC;
   end

   incPcTracksModel: assert property (@(posedge clk) disable iff (!rstN)
      incPC == modelSum[addrWidth-1:0])
      else begin
         failCount++;
         $error("error incPC got %h expected %h", $sampled(incPC),
                $sampled(modelSum[addrWidth-1:0]));
      end

   wordWhenFree: assert property (@(posedge clk) disable iff (!rstN)
      !expHold |-> instruction == fetched)
      else begin
         failCount++;
         $error("error instruction got %h expected %h", $sampled(instruction),
                $sampled(fetched));
      end

   nopWhenHeld: assert property (@(posedge clk) disable iff (!rstN)
      expHold |-> instruction == nopInstr)
      else begin
         failCount++;
         $error("error instruction got %h expected %h", $sampled(instruction), nopInstr);
      end

   branchFlag: assert property (@(posedge clk) disable iff (!rstN)
      branchInstF == expBranch)
      else begin
         failCount++;
         $error("error branchInstF got %h expected %h", $sampled(branchInstF),
                $sampled(expBranch));
      end

   advanceWhenFree: assert property (@(posedge clk) disable iff (!rstN)
      !expHold && !createDump |=> incPC == prevIncPC + addrWidth'(pcStep))
      else begin
         failCount++;
         $error("error incPC got %h expected %h", $sampled(incPC),
                $sampled(prevIncPC) + addrWidth'(pcStep));
      end

   // data hazard alone stalls the PC
   stallOnData: assert property (@(posedge clk) disable iff (!rstN)
      dataHaz && !stageM.branch |=> incPC == prevIncPC)
      else begin
         failCount++;
         $error("error incPC got %h expected %h", $sampled(incPC), $sampled(prevIncPC));
      end

   redirectTarget: assert property (@(posedge clk) disable iff (!rstN)
      stageM.branch && !createDump |=> incPC == prevNewPC + addrWidth'(pcStep))
      else begin
         failCount++;
         $error("error incPC got %h expected %h", $sampled(incPC),
                $sampled(prevNewPC) + addrWidth'(pcStep));
      end

   dumpFreezes: assert property (@(posedge clk) disable iff (!rstN)
      createDump |=> incPC == prevIncPC)
      else begin
         failCount++;
         $error("error incPC got %h expected %h", $sampled(incPC), $sampled(prevIncPC));
      end

   errIsCarry: assert property (@(posedge clk) disable iff (!rstN)
      err == modelSum[addrWidth])
      else begin
         failCount++;
         $error("error err got %h expected %h", $sampled(err), $sampled(modelSum[addrWidth]));
      end

   errAfterTopRedirect: assert property (@(posedge clk) disable iff (!rstN)
      stageM.branch && newPC == 16'hFFFE && !createDump |=> err)
      else begin
         failCount++;
         $error("error err got %h expected 1 after redirect to fffe", $sampled(err));
      end

endmodule

bind fetch fetchProperties uProps (.*);

/* bench/fetchTb.sv */
// fetch stage testbench
`timescale 1ns/100ps

module fetchTb;

   import fetchPkg::*;

   localparam int unsigned runCycles     = 2000;
   localparam int unsigned resetCycles   = 16;
   localparam int unsigned watchdogLimit = 4000;

   // legal opcodes for the random program
   localparam opcodeT opTable [13] = '{
      HALT, NOP, ADDI, SUBI, ST, LD, BEQZ,
      BNEZ, J, JR, JAL, ADD, LBI
   };

   logic                  clk;
   logic                  rstN;
   logic [addrWidth-1:0]  newPC;
   logic                  createDump;
   stageInfoT             stageD;
   stageInfoT             stageX;
   stageInfoT             stageM;
   stageInfoT             stageW;
   memLoadT               memLoad;
   logic [instrWidth-1:0] instruction;
   logic [addrWidth-1:0]  incPC;
   logic                  branchInstF;
   logic                  err;
   logic [31:0]           lcgState;

   fetch i_dut (
      .clk         (clk),
      .rstN        (rstN),
      .newPC       (newPC),
      .createDump  (createDump),
      .stageD      (stageD),
      .stageX      (stageX),
      .stageM      (stageM),
      .stageW      (stageW),
      .memLoad     (memLoad),
      .instruction (instruction),
      .incPC       (incPC),
      .branchInstF (branchInstF),
      .err         (err)
   );

   initial clk = 1'b0;
   always #2 clk = ~clk;

   function automatic logic [31:0] nextRandom();
      lcgState = lcgState * 32'd1664525 + 32'd1013904223;
      return lcgState;
   endfunction

   // about half the stages write, one in eight carries a branch
   function automatic stageInfoT randomStage();
      logic [31:0] r;
      stageInfoT   s;
      r = nextRandom();
      s.regWrite.en  = r[31];
      s.regWrite.idx = r[29:27];
      s.branch       = (r[26:24] == 3'b000);
      return s;
   endfunction

   initial begin
      logic [31:0] r;
      memLoadT     ld;
      int unsigned addr;
      int unsigned cycle;
      lcgState   = 32'h1466;
      rstN       = 1'b0;
      newPC      = '0;
      createDump = 1'b1;
      stageD     = '0;
      stageX     = '0;
      stageM     = '0;
      stageW     = '0;
      memLoad    = '0;
      // PC stays frozen by dump until the program is in
      for (addr = 0; addr < memDepth; addr++) begin
         @(posedge clk);
         r       = nextRandom();
         ld.en   = 1'b1;
         ld.addr = memAddrWidth'(addr);
         ld.data = {opTable[r[31:16] % 13], r[10:0]};
         memLoad <= ld;
         if (addr == resetCycles) begin
            rstN <= 1'b1;
         end
      end
      @(posedge clk);
      memLoad    <= '0;
      createDump <= 1'b0;
      for (cycle = 0; cycle < runCycles; cycle++) begin
         @(posedge clk);
         stageD <= randomStage();
         stageX <= randomStage();
         stageM <= randomStage();
         stageW <= randomStage();
         r = nextRandom();
         // top of the address space now and then, to reach the overflow
         newPC      <= (r[31:28] == 4'h0) ? 16'hFFFE : {r[22:8], 1'b0};
         createDump <= (r[27:24] == 4'h0);
      end
      @(negedge clk);
      if (i_dut.uProps.failCount == 0) begin
         $display("STATUS: PASS");
         $finish;
      end else begin
         $display("STATUS: FAIL");
         $fatal(1, "%0d assertion failures", i_dut.uProps.failCount);
      end
   end

   // stop at the first failed assertion
   always @(negedge clk) begin
      if (i_dut.uProps.failCount != 0) begin
         $display("STATUS: FAIL");
         $fatal(1, "assertion failure in the fetch checks");
      end
   end

   initial begin
      int unsigned ticks;
      ticks = 0;
      while (ticks < watchdogLimit) begin
         @(posedge clk);
         ticks++;
      end
      $display("STATUS: FAIL");
      $fatal(1, "simulation did not finish within %0d cycles", watchdogLimit);
   end

endmodule

/* fetch.f */
src/fetchPkg.sv
src/pcUnit.sv
src/instrMem.sv
src/hazardCtrl.sv
src/fetch.sv
bench/fetch_properties.sv
bench/fetchTb.sv

/* Bender.yml */
package:
  name: fetch

sources:
  - src/fetchPkg.sv
  - src/pcUnit.sv
  - src/instrMem.sv
  - src/hazardCtrl.sv
  - src/fetch.sv
  - target: test
    files:
      - bench/fetch_properties.sv
      - bench/fetchTb.sv
